// ==== flist.f ====
hw/audio_soc_pkg.sv
hw/ram_bus_if.sv
hw/cpu_bus_logic.sv
hw/bus_ram.sv
hw/audio_fifo.sv
hw/audio_serializer.sv
hw/audio_soc_top.sv
sim/tb_audio_soc.sv

// ==== sim/tb_audio_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_audio_soc;

   localparam int RAM_ADDR_BITS = audio_soc_pkg::RAM_ADDR_BITS;
   localparam int FIFO_DEPTH_LOG2 = 4;
   localparam int BCLK_DIV = 4;
   // twice the time of all frames on the wire plus the bus traffic
   localparam int FRAMES = 48;
   localparam int BUS_OPS = 600;
   localparam int WATCHDOG_CYCLES = 2 * (FRAMES * 48 * 2 * BCLK_DIV + BUS_OPS * 4);
   // one bclk period is two toggles of BCLK_DIV cycles of 10 ns
   localparam int BCLK_PERIOD_NS = 2 * BCLK_DIV * 10;

   logic clk;
   logic reset;
   audio_soc_pkg::word_t addr;
   audio_soc_pkg::word_t wdata;
   audio_soc_pkg::strb_t wstrb;
   logic valid;
   audio_soc_pkg::word_t rdata;
   logic ready;
   logic [7:0] dip;
   logic [4:0] buttons;
   logic [7:0] led;
   logic codec_init_done;
   logic bclk;
   logic lrclk;
   logic sdata;

   logic [31:0] rng_state;
   int last_latency;
   logic saw_full;
   audio_soc_pkg::stereo_t rx_q[$];
   audio_soc_pkg::stereo_t exp_q[$];

   audio_soc_top #(
      .RAM_ADDR_BITS(RAM_ADDR_BITS),
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
      .BCLK_DIV(BCLK_DIV)
   ) UUT (
      .clk(clk),
      .reset(reset),
      .addr(addr),
      .wdata(wdata),
      .wstrb(wstrb),
      .valid(valid),
      .rdata(rdata),
      .ready(ready),
      .dip(dip),
      .buttons(buttons),
      .led(led),
      .codec_init_done(codec_init_done),
      .bclk(bclk),
      .lrclk(lrclk),
      .sdata(sdata)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   task automatic abort_run();
      $display("*** FAILED ***");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [47:0] got,
                              input logic [47:0] want);
      assert (got === want)
      else begin
         $display("error: %s got 0x%0h expected 0x%0h", name, got, want);
         abort_run();
      end
   endtask

   // valid is held until ready is seen at a rising edge
   task automatic bus_access(input audio_soc_pkg::word_t a, input audio_soc_pkg::word_t d,
                             input audio_soc_pkg::strb_t s,
                             output audio_soc_pkg::word_t q);
      @(negedge clk);
      addr = a;
      wdata = d;
      wstrb = s;
      valid = 1'b1;
      last_latency = 0;
      @(posedge clk);
      while (ready !== 1'b1) begin
         last_latency++;
         @(posedge clk);
      end
      q = rdata;
      @(negedge clk);
      valid = 1'b0;
      wstrb = '0;
   endtask

   task automatic cpu_write(input audio_soc_pkg::word_t a, input audio_soc_pkg::word_t d,
                            input audio_soc_pkg::strb_t s);
      audio_soc_pkg::word_t unused;
      bus_access(a, d, s, unused);
   endtask

   task automatic cpu_read(input audio_soc_pkg::word_t a, output audio_soc_pkg::word_t q);
      bus_access(a, 32'h0, 4'b0000, q);
   endtask

   task automatic wait_not_full();
      audio_soc_pkg::word_t q;
      cpu_read(audio_soc_pkg::ADDR_AUDIO_STATUS, q);
      while (q[0]) begin
         saw_full = 1'b1;
         repeat (16) @(posedge clk);
         cpu_read(audio_soc_pkg::ADDR_AUDIO_STATUS, q);
      end
   endtask

   // byte 3 of each word carries noise that must be dropped
   task automatic write_pair();
      logic [31:0] l;
      logic [31:0] r;
      l = next_random();
      r = next_random();
      cpu_write(audio_soc_pkg::ADDR_AUDIO_LEFT, l, 4'b1111);
      cpu_write(audio_soc_pkg::ADDR_AUDIO_RIGHT, r, 4'b1111);
      exp_q.push_back({l[23:0], r[23:0]});
   endtask

   task automatic push_pair();
      wait_not_full();
      write_pair();
   endtask

   // idle zero frames may sit between the expected pairs
   task automatic expect_stream();
      audio_soc_pkg::stereo_t got;
      audio_soc_pkg::stereo_t want;
      while (exp_q.size() > 0) begin
         want = exp_q.pop_front();
         got = '0;
         while (got == '0) begin
            while (rx_q.size() == 0) begin
               @(posedge clk);
            end
            got = rx_q.pop_front();
         end
         check_value("sdata frame", got, want);
      end
   endtask

   task automatic zero_frames(input int n);
      rx_q.delete();
      while (rx_q.size() < n) begin
         @(posedge clk);
      end
      for (int i = 0; i < n; i++) begin
         check_value("sdata idle frame", rx_q[i], '0);
      end
   endtask

   task automatic register_reads();
      audio_soc_pkg::word_t q;
      audio_soc_pkg::word_t unmapped [3] = '{32'h8000_0018, 32'h0000_0100, 32'h0001_8000};
      logic [31:0] r;
      r = next_random();
      @(negedge clk);
      dip = r[7:0];
      buttons = r[12:8];
      cpu_read(audio_soc_pkg::ADDR_DIP, q);
      check_value("rdata (dip)", q, {24'b0, r[7:0]});
      check_value("ready latency", last_latency, 0);
      cpu_read(audio_soc_pkg::ADDR_BUTTONS, q);
      check_value("rdata (buttons)", q, {27'b0, r[12:8]});
      codec_init_done = 1'b1;
      cpu_read(audio_soc_pkg::ADDR_AUDIO_STATUS, q);
      check_value("rdata (status)", q, 32'h0000_0002);
      codec_init_done = 1'b0;
      cpu_read(audio_soc_pkg::ADDR_AUDIO_STATUS, q);
      check_value("rdata (status)", q, 32'h0000_0000);
      foreach (unmapped[i]) begin
         cpu_read(unmapped[i], q);
         check_value("rdata (unmapped)", q, 32'h0);
         check_value("ready latency", last_latency, 0);
      end
      codec_init_done = 1'b1;
   endtask

   task automatic led_register();
      audio_soc_pkg::word_t q;
      cpu_write(audio_soc_pkg::ADDR_LED, 32'h0000_00a5, 4'b0001);
      check_value("led", led, 8'ha5);
      cpu_read(audio_soc_pkg::ADDR_LED, q);
      check_value("rdata (led)", q, 32'h0000_00a5);
      // lane 0 not strobed
      cpu_write(audio_soc_pkg::ADDR_LED, 32'hffff_ff3c, 4'b1110);
      check_value("led", led, 8'ha5);
   endtask

   task automatic ram_readback();
      audio_soc_pkg::word_t addrs [16];
      audio_soc_pkg::word_t model [16];
      audio_soc_pkg::word_t q;
      audio_soc_pkg::word_t d;
      audio_soc_pkg::strb_t s;
      logic [31:0] r;
      int k;
      for (int i = 0; i < 16; i++) begin
         r = next_random();
         // top 4 word-address bits from i keep the addresses distinct
         addrs[i] = audio_soc_pkg::RAM_BASE + {i[3:0], r[8:0], 2'b00};
         d = next_random();
         cpu_write(addrs[i], d, 4'b1111);
         check_value("ready latency (ram write)", last_latency, 1);
         model[i] = d;
      end
      for (int i = 0; i < 8; i++) begin
         r = next_random();
         k = r[3:0];
         s = r[7:4];
         if (s == 4'b0000) begin
            s = 4'b0110;
         end
         d = next_random();
         cpu_write(addrs[k], d, s);
         for (int lane = 0; lane < 4; lane++) begin
            if (s[lane]) begin
               model[k][8*lane +: 8] = d[8*lane +: 8];
            end
         end
      end
      for (int i = 0; i < 16; i++) begin
         cpu_read(addrs[i], q);
         check_value("rdata (ram)", q, model[i]);
         check_value("ready latency (ram read)", last_latency, 1);
      end
   endtask

   task automatic sample_strobes();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      a = next_random();
      b = next_random();
      r = next_random();
      wait_not_full();
      cpu_write(audio_soc_pkg::ADDR_AUDIO_LEFT, a, 4'b0111);
      cpu_write(audio_soc_pkg::ADDR_AUDIO_LEFT, b, 4'b1101);
      cpu_write(audio_soc_pkg::ADDR_AUDIO_RIGHT, r, 4'b1111);
      // bytes 0 and 2 from the second write, byte 1 kept from the first
      exp_q.push_back({b[23:16], a[15:8], b[7:0], r[23:0]});
      expect_stream();
   endtask

   task automatic stream_order();
      repeat (8) begin
         push_pair();
      end
      expect_stream();
      zero_frames(2);
   endtask

   task automatic back_pressure();
      audio_soc_pkg::word_t q;
      saw_full = 1'b0;
      repeat (20) begin
         push_pair();
      end
      assert (saw_full)
      else begin
         $display("status bit 0 never showed a full FIFO while it was being filled");
         abort_run();
      end
      // still full after the last push, so this pair waits in push_valid for a pop
      cpu_read(audio_soc_pkg::ADDR_AUDIO_STATUS, q);
      check_value("status bit 0", q[0], 1'b1);
      write_pair();
      expect_stream();
      cpu_read(audio_soc_pkg::ADDR_AUDIO_STATUS, q);
      check_value("status bit 0", q[0], 1'b0);
      zero_frames(2);
   endtask

   // one bit per rising bclk and 48 bits per frame
   initial begin : receiver
      audio_soc_pkg::stereo_t frame;
      int nbits;
      time last_rise;
      frame = '0;
      nbits = 0;
      last_rise = 0;
      wait (reset === 1'b0);
      // the first rising bclk comes before any bit is shifted out
      @(negedge bclk);
      forever begin
         @(posedge bclk);
         if (last_rise != 0) begin
            check_value("bclk period (ns)", $time - last_rise, BCLK_PERIOD_NS);
         end
         last_rise = $time;
         assert (lrclk === (nbits >= 24))
         else begin
            $display("error: lrclk got 0x%0h expected 0x%0h at frame bit %0d",
                     lrclk, (nbits >= 24), nbits);
            abort_run();
         end
         frame = {frame[46:0], sdata};
         nbits++;
         if (nbits == 48) begin
            rx_q.push_back(frame);
            nbits = 0;
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      addr = '0;
      wdata = '0;
      wstrb = '0;
      valid = 1'b0;
      dip = '0;
      buttons = '0;
      codec_init_done = 1'b0;
      rng_state = 32'h0abba169;
      last_latency = 0;
      saw_full = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      register_reads();
      led_register();
      ram_readback();
      sample_strobes();
      stream_order();
      back_pressure();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/audio_soc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_soc_top #(
   parameter int RAM_ADDR_BITS = audio_soc_pkg::RAM_ADDR_BITS,
   parameter int FIFO_DEPTH_LOG2 = 4,
   parameter int BCLK_DIV = 4
) (
   input wire logic clk,
   input wire logic reset,

   // cpu bus
   input wire audio_soc_pkg::word_t addr,
   input wire audio_soc_pkg::word_t wdata,
   input wire audio_soc_pkg::strb_t wstrb,
   input wire logic valid,
   output audio_soc_pkg::word_t rdata,
   output logic ready,

   // board i/o
   input wire logic [7:0] dip,
   input wire logic [4:0] buttons,
   output logic [7:0] led,

   // codec
   input wire logic codec_init_done,
   output logic bclk,
   output logic lrclk,
   output logic sdata
);

   // sample push
   audio_soc_pkg::stereo_t push_data;
   logic push_valid;
   logic fifo_full;

   // fifo to serializer
   audio_soc_pkg::stereo_t pop_data;
   logic pop;
   logic fifo_empty;

   ram_bus_if #(.ADDR_BITS(RAM_ADDR_BITS)) ram_bus ();

   cpu_bus_logic #(
      .RAM_ADDR_BITS(RAM_ADDR_BITS)
   ) bus_logic (
      .clk(clk),
      .reset(reset),
      .addr(addr),
      .wdata(wdata),
      .wstrb(wstrb),
      .valid(valid),
      .rdata(rdata),
      .ready(ready),
      .dip(dip),
      .buttons(buttons),
      .led(led),
      .codec_init_done(codec_init_done),
      .fifo_full(fifo_full),
      .push_data(push_data),
      .push_valid(push_valid),
      .ram(ram_bus.requester)
   );

   bus_ram #(
      .RAM_ADDR_BITS(RAM_ADDR_BITS)
   ) ram (
      .clk(clk),
      .reset(reset),
      .mem(ram_bus.memory)
   );

   audio_fifo #(
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) fifo (
      .clk(clk),
      .reset(reset),
      .push_data(push_data),
      .push_valid(push_valid),
      .fifo_full(fifo_full),
      .pop(pop),
      .fifo_empty(fifo_empty),
      .pop_data(pop_data)
   );

   audio_serializer #(
      .BCLK_DIV(BCLK_DIV)
   ) serializer (
      .clk(clk),
      .reset(reset),
      .pop_data(pop_data),
      .fifo_empty(fifo_empty),
      .pop(pop),
      .bclk(bclk),
      .lrclk(lrclk),
      .sdata(sdata)
   );

endmodule

`default_nettype wire

// ==== hw/audio_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_serializer #(
   parameter int BCLK_DIV = 4
) (
   input wire logic clk,
   input wire logic reset,

   // fifo head
   input wire audio_soc_pkg::stereo_t pop_data,
   input wire logic fifo_empty,
   output logic pop,

   // serial output
   output logic bclk,
   output logic lrclk,
   output logic sdata
);

   localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;

   typedef enum logic [1:0] {
      S_IDLE,
      S_LOAD,
      S_SHIFT
   } state_t;

   state_t state;
   logic [DIV_W-1:0] div_cnt;
   logic [5:0] bit_idx;
   audio_soc_pkg::stereo_t shift_reg;
   logic tick;
   logic fall;

   // bclk toggles on tick, falls when it is high
   assign tick = (div_cnt == DIV_W'(BCLK_DIV - 1));
   assign fall = tick && bclk;

   // take the head only at a frame boundary
   assign pop = (state == S_LOAD) && !fifo_empty;

   // bit clock divider, parked low until framing starts
   always_ff @(posedge clk) begin
      if (reset || state == S_IDLE) begin
         div_cnt <= '0;
         bclk <= 1'b0;
      end else if (tick) begin
         div_cnt <= '0;
         bclk <= ~bclk;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // frame control
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_IDLE;
         bit_idx <= '0;
         lrclk <= 1'b0;
         sdata <= 1'b0;
      end else begin
         case (state)
            S_IDLE: state <= S_LOAD;
            S_LOAD: begin
               bit_idx <= '0;
               state <= S_SHIFT;
            end
            S_SHIFT: begin
               if (fall) begin
                  sdata <= shift_reg[47];
                  // left half with lrclk low, right half high
                  lrclk <= (bit_idx >= 6'd24);
                  if (bit_idx == 6'd47) begin
                     state <= S_LOAD;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // frame data, msb first; zeros when the fifo runs dry
   always_ff @(posedge clk) begin
      if (state == S_LOAD) begin
         shift_reg <= fifo_empty ? '0 : pop_data;
      end else if (state == S_SHIFT && fall) begin
         shift_reg <= {shift_reg[46:0], 1'b0};
      end
   end

endmodule

`default_nettype wire

// ==== hw/audio_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input wire logic clk,
   input wire logic reset,

   // write side
   input wire audio_soc_pkg::stereo_t push_data,
   input wire logic push_valid,
   output logic fifo_full,

   // read side
   input wire logic pop,
   output logic fifo_empty,
   output audio_soc_pkg::stereo_t pop_data
);

   localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

   audio_soc_pkg::stereo_t buffer [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   // one extra bit so full and empty differ
   logic [FIFO_DEPTH_LOG2:0] count;
   logic do_push;
   logic do_pop;

   assign fifo_full = (count == (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
   assign fifo_empty = (count == '0);
   assign do_push = push_valid && !fifo_full;
   assign do_pop = pop && !fifo_empty;

   // head entry shows without a read cycle
   assign pop_data = buffer[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         buffer[wr_ptr] <= push_data;
      end
   end

   // pointers wrap naturally at the power-of-two depth
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            // both or neither leave occupancy unchanged
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/bus_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_ram #(
   parameter int RAM_ADDR_BITS = audio_soc_pkg::RAM_ADDR_BITS
) (
   input wire logic clk,
   input wire logic reset,
   ram_bus_if.memory mem
);

   localparam int WORDS = 2 ** RAM_ADDR_BITS;

   audio_soc_pkg::word_t ram_array [WORDS];
   audio_soc_pkg::word_t rdata_q;
   logic ack_q;
   logic do_write;

   assign do_write = mem.req && (mem.wstrb != 4'b0000);

   // byte-lane writes
   always_ff @(posedge clk) begin
      if (do_write) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (mem.wstrb[lane]) begin
               ram_array[mem.word_addr][8*lane +: 8] <= mem.wdata[8*lane +: 8];
            end
         end
      end
   end

   // registered read, old word on a write cycle
   always_ff @(posedge clk) begin
      if (mem.req) begin
         rdata_q <= ram_array[mem.word_addr];
      end
   end

   // one ack per request
   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= mem.req;
      end
   end

   assign mem.rdata = rdata_q;
   assign mem.ack = ack_q;

endmodule

`default_nettype wire

// ==== hw/cpu_bus_logic.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_logic #(
   parameter int RAM_ADDR_BITS = audio_soc_pkg::RAM_ADDR_BITS
) (
   input wire logic clk,
   input wire logic reset,

   // cpu side
   input wire audio_soc_pkg::word_t addr,
   input wire audio_soc_pkg::word_t wdata,
   input wire audio_soc_pkg::strb_t wstrb,
   input wire logic valid,
   output audio_soc_pkg::word_t rdata,
   output logic ready,

   // board i/o
   input wire logic [7:0] dip,
   input wire logic [4:0] buttons,
   output logic [7:0] led,

   // audio path
   input wire logic codec_init_done,
   input wire logic fifo_full,
   output audio_soc_pkg::stereo_t push_data,
   output logic push_valid,

   ram_bus_if.requester ram
);

   audio_soc_pkg::sample_t left_sample;
   audio_soc_pkg::sample_t right_sample;
   logic ram_hit;
   logic reg_write;

   // merge strobed bytes 0..2 of a bus word into a sample
   function automatic audio_soc_pkg::sample_t merge_sample(
      input audio_soc_pkg::sample_t old_val,
      input audio_soc_pkg::word_t data,
      input audio_soc_pkg::strb_t strb
   );
      audio_soc_pkg::sample_t result;
      result = old_val;
      for (int i = 0; i < 3; i++) begin
         if (strb[i]) begin
            result[8*i +: 8] = data[8*i +: 8];
         end
      end
      return result;
   endfunction

   assign ram_hit = (addr >= audio_soc_pkg::RAM_BASE) && (addr <= audio_soc_pkg::RAM_LIMIT);

   // registers complete in the valid cycle, so any write strobe is a write
   assign reg_write = valid && (wstrb != 4'b0000);

   // ram request, dropped in the ack cycle so one access is taken once
   assign ram.word_addr = addr[RAM_ADDR_BITS+1:2];
   assign ram.wdata = wdata;
   assign ram.wstrb = wstrb;
   assign ram.req = valid && ram_hit && !ram.ack;

   assign push_data = {left_sample, right_sample};

   // read mux and ready
   always_comb begin
      ready = 1'b1;
      rdata = '0;
      if (ram_hit) begin
         ready = ram.ack;
         rdata = ram.rdata;
      end else begin
         case (addr)
            audio_soc_pkg::ADDR_DIP: rdata = {24'b0, dip};
            audio_soc_pkg::ADDR_LED: rdata = {24'b0, led};
            audio_soc_pkg::ADDR_BUTTONS: rdata = {27'b0, buttons};
            audio_soc_pkg::ADDR_AUDIO_STATUS: rdata = {30'b0, codec_init_done, fifo_full};
            // sample registers are write-only, unmapped reads zero
            default: rdata = '0;
         endcase
      end
   end

   // register writes
   always_ff @(posedge clk) begin
      if (reset) begin
         led <= 8'h00;
         left_sample <= '0;
         right_sample <= '0;
         push_valid <= 1'b0;
      end else begin
         // fifo took the pair this cycle
         if (push_valid && !fifo_full) begin
            push_valid <= 1'b0;
         end
         if (reg_write) begin
            case (addr)
               audio_soc_pkg::ADDR_LED: begin
                  if (wstrb[0]) begin
                     led <= wdata[7:0];
                  end
               end
               audio_soc_pkg::ADDR_AUDIO_LEFT: begin
                  left_sample <= merge_sample(left_sample, wdata, wstrb);
               end
               audio_soc_pkg::ADDR_AUDIO_RIGHT: begin
                  right_sample <= merge_sample(right_sample, wdata, wstrb);
                  // held until the fifo has room
                  push_valid <= 1'b1;
               end
               default: begin
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/ram_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface ram_bus_if #(
   parameter int ADDR_BITS = audio_soc_pkg::RAM_ADDR_BITS
);

   // request side
   logic [ADDR_BITS-1:0] word_addr;
   audio_soc_pkg::word_t wdata;
   audio_soc_pkg::strb_t wstrb;
   logic req;

   // response side, ack pulses one cycle after req rises
   audio_soc_pkg::word_t rdata;
   logic ack;

   modport requester (
      output word_addr, wdata, wstrb, req,
      input rdata, ack
   );

   modport memory (
      input word_addr, wdata, wstrb, req,
      output rdata, ack
   );

endinterface

`default_nettype wire

// ==== hw/audio_soc_pkg.sv ====
`default_nettype none

package audio_soc_pkg;

   // bus word, used for both addresses and data
   typedef logic [31:0] word_t;

   // one bit per byte lane, nonzero means write
   typedef logic [3:0] strb_t;

   // one channel of audio
   typedef logic signed [23:0] sample_t;

   // left in [47:24], right in [23:0]
   typedef logic [47:0] stereo_t;

   // ram window, 32 KB
   localparam word_t RAM_BASE = 32'h0001_0000;
   localparam word_t RAM_LIMIT = 32'h0001_7fff;

   // memory-mapped registers
   localparam word_t ADDR_DIP = 32'h8000_0000;
   localparam word_t ADDR_LED = 32'h8000_0004;
   localparam word_t ADDR_BUTTONS = 32'h8000_0008;
   // bit 0 fifo full, bit 1 codec configured
   localparam word_t ADDR_AUDIO_STATUS = 32'h8000_000c;
   localparam word_t ADDR_AUDIO_LEFT = 32'h8000_0010;
   // a write here pushes the stereo pair
   localparam word_t ADDR_AUDIO_RIGHT = 32'h8000_0014;

   // 8 K words fill the ram window
   localparam int RAM_ADDR_BITS = 13;

endpackage

`default_nettype wire
